/* tile_settings.svh */
// ----------------------------------------------------------------------
// Widths, counts and command codes shared by the tile memory glue
// TILE_REQ_WORDS must be a power of two, lane index comes from addr bits
// Event indices below fix the bit order of the PMU event vector
// ----------------------------------------------------------------------
`ifndef TILE_SETTINGS_SVH
`define TILE_SETTINGS_SVH

// Walker and data-cache side
`define TILE_ADDR_W          40
`define TILE_DATA_W          64
`define TILE_REQ_WORDS       2
`define TILE_OFFSET_W        5
`define TILE_SET_W           7
`define TILE_PTW_CMD_W       5
`define TILE_PTW_CMD_AMO_OR  5'b01010

// L2 grant side
`define TILE_L2_LINE_W       512
`define TILE_L2_BEAT_W       2
`define TILE_INVAL_ADDR_W    12

// Performance monitor
`define TILE_PMU_CNT_W       32
`define TILE_PMU_NEVT        4
`define TILE_EVT_L2_HIT      0
`define TILE_EVT_ITLB_STALL  1
`define TILE_EVT_PTW_REQ     2
`define TILE_EVT_PTW_AMO     3

`endif

/* tile_pkg.sv */
// ----------------------------------------------------------------------
// Types for the tile memory glue, widths come from tile_settings.svh
// Data-cache wdata, be and rdata hold one entry per request lane
// ----------------------------------------------------------------------
`include "tile_settings.svh"

package tile_pkg;

    // ------------------------------------------------------------------
    // Plain vectors
    // ------------------------------------------------------------------
    typedef logic [`TILE_ADDR_W-1:0]                          addr_t;
    typedef logic [`TILE_DATA_W-1:0]                          data_t;
    typedef logic [`TILE_DATA_W/8-1:0]                        be_t;
    typedef logic [$clog2(`TILE_REQ_WORDS)-1:0]               lane_idx_t;
    typedef logic [`TILE_OFFSET_W+`TILE_SET_W-1:0]            addr_offset_t;
    typedef logic [`TILE_ADDR_W-`TILE_OFFSET_W-`TILE_SET_W-1:0] addr_tag_t;
    typedef logic [`TILE_PTW_CMD_W-1:0]                       ptw_cmd_t;
    typedef logic [`TILE_L2_LINE_W-1:0]                       l2_line_t;
    typedef logic [`TILE_L2_BEAT_W-1:0]                       l2_beat_t;
    typedef logic [`TILE_INVAL_ADDR_W-1:0]                    inval_addr_t;
    typedef logic [`TILE_PMU_CNT_W-1:0]                       pmu_cnt_t;
    typedef logic [$clog2(`TILE_PMU_NEVT)-1:0]                pmu_sel_t;
    typedef logic [`TILE_PMU_NEVT-1:0]                        pmu_evt_t;

    typedef enum logic {
        DMEM_OP_LOAD,
        DMEM_OP_AMO_OR
    } dmem_op_e;

    typedef enum logic {
        BR_IDLE,
        BR_WAIT_RSP
    } bridge_state_e;

    // ------------------------------------------------------------------
    // Bundles
    // ------------------------------------------------------------------
    typedef struct packed {
        logic     valid;
        ptw_cmd_t cmd;
        logic [2:0] size;
        addr_t    addr;
        data_t    data;
    } ptw_dmem_req_t;

    typedef struct packed {
        logic  valid;
        data_t data;
    } ptw_dmem_rsp_t;

    typedef struct packed {
        logic                             valid;
        addr_offset_t                     addr_offset;
        addr_tag_t                        addr_tag;
        dmem_op_e                         op;
        logic [2:0]                       size;
        logic                             need_rsp;
        logic                             phys_indexed;
        data_t [`TILE_REQ_WORDS-1:0]      wdata;
        be_t   [`TILE_REQ_WORDS-1:0]      be;
    } dcache_req_t;

    typedef struct packed {
        logic                             valid;
        data_t [`TILE_REQ_WORDS-1:0]      rdata;
    } dcache_rsp_t;

    typedef struct packed {
        logic        valid;
        l2_line_t    data;
        l2_beat_t    beat;
        logic        inval;
        inval_addr_t inval_addr;
        logic        l2_hit;    // Grant served from L2 without a miss
    } l2_grant_t;

    typedef struct packed {
        logic        valid;
        logic        ack;       // Last beat of the fill
        l2_line_t    data;
        logic        inv_valid;
        inval_addr_t inv_paddr;
    } ifill_resp_t;

endpackage

/* ptw_dmem_bridge.sv */
// ----------------------------------------------------------------------
// Walker memory requests onto data-cache requester port 0
// One walker access in flight, the cache must not answer unasked
// Lane is the address bit above the word offset, latched on acceptance
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`include "tile_settings.svh"

module ptw_dmem_bridge (
    input  logic                   clk_i,
    input  logic                   rst_i,

    // Walker side
    input  tile_pkg::ptw_dmem_req_t ptw_req_i,
    output logic                   ptw_ready_o,
    output tile_pkg::ptw_dmem_rsp_t ptw_rsp_o,

    // Data cache side
    output tile_pkg::dcache_req_t  dcache_req_o,
    input  logic                   dcache_ready_i,
    input  tile_pkg::dcache_rsp_t  dcache_rsp_i,

    // Bit 0 request accepted, bit 1 AMO accepted
    output logic [1:0]             ptw_evt_o
);

    localparam int unsigned WordOffW = $clog2(`TILE_DATA_W/8);
    localparam int unsigned LaneW    = $clog2(`TILE_REQ_WORDS);
    localparam int unsigned IdxW     = `TILE_OFFSET_W + `TILE_SET_W;

    tile_pkg::bridge_state_e state_q, state_d;
    tile_pkg::lane_idx_t     req_lane;
    tile_pkg::lane_idx_t     lane_q;
    logic                    is_amo;
    logic                    accept;

    assign req_lane = ptw_req_i.addr[WordOffW +: LaneW];
    assign is_amo   = (ptw_req_i.cmd == `TILE_PTW_CMD_AMO_OR);

    // ------------------------------------------------------------------
    // Request formatting
    // ------------------------------------------------------------------
    always_comb begin
        dcache_req_o.valid        = ptw_req_i.valid && (state_q == tile_pkg::BR_IDLE);
        dcache_req_o.addr_offset  = ptw_req_i.addr[IdxW-1:0];
        dcache_req_o.addr_tag     = ptw_req_i.addr[`TILE_ADDR_W-1:IdxW];
        dcache_req_o.op           = is_amo ? tile_pkg::DMEM_OP_AMO_OR
                                           : tile_pkg::DMEM_OP_LOAD;
        dcache_req_o.size         = ptw_req_i.size;
        dcache_req_o.need_rsp     = 1'b1;
        dcache_req_o.phys_indexed = 1'b1;
        for (int i = 0; i < `TILE_REQ_WORDS; i++) begin
            if (tile_pkg::lane_idx_t'(i) == req_lane) begin
                dcache_req_o.wdata[i] = ptw_req_i.data;
                dcache_req_o.be[i]    = is_amo ? '1 : '0; // Loads write nothing
            end else begin
                dcache_req_o.wdata[i] = '0;
                dcache_req_o.be[i]    = '0;
            end
        end
    end

    assign accept      = dcache_req_o.valid && dcache_ready_i;
    assign ptw_ready_o = (state_q == tile_pkg::BR_IDLE) && dcache_ready_i;

    assign ptw_evt_o[0] = accept;
    assign ptw_evt_o[1] = accept && is_amo;

    // ------------------------------------------------------------------
    // Outstanding access tracking
    // ------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            tile_pkg::BR_IDLE: begin
                if (accept) begin
                    state_d = tile_pkg::BR_WAIT_RSP;
                end
            end
            tile_pkg::BR_WAIT_RSP: begin
                if (dcache_rsp_i.valid) begin
                    state_d = tile_pkg::BR_IDLE;  // Zero-cycle turnaround
                end
            end
            default: state_d = tile_pkg::BR_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= tile_pkg::BR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            lane_q <= req_lane;
        end
    end

    // Response word from the lane seen at acceptance
    assign ptw_rsp_o.valid = (state_q == tile_pkg::BR_WAIT_RSP) && dcache_rsp_i.valid;
    assign ptw_rsp_o.data  = dcache_rsp_i.rdata[lane_q];

    // ------------------------------------------------------------------
    // Protocol checks
    // ------------------------------------------------------------------
    a_no_rsp_in_idle: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (state_q == tile_pkg::BR_IDLE) |-> !dcache_rsp_i.valid
    );

    a_held_req_stable: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (ptw_req_i.valid && !ptw_ready_o) |=> (ptw_req_i.valid && $stable(ptw_req_i.addr))
    );

endmodule

/* icache_fill_port.sv */
// ----------------------------------------------------------------------
// L2 grant registered into the instruction-fill response
// Output and L2-hit event lag the grant by exactly one cycle
// Fill is acknowledged on the last beat only
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module icache_fill_port (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  tile_pkg::l2_grant_t   l2_grant_i,
    output tile_pkg::ifill_resp_t ifill_resp_o,
    output logic                  l2_hit_evt_o
);

    logic                  valid_q;
    logic                  ack_q;
    logic                  l2_hit_q;
    tile_pkg::l2_line_t    data_q;
    logic                  inv_valid_q;
    tile_pkg::inval_addr_t inv_paddr_q;

    // Control part
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q  <= 1'b0;
            ack_q    <= 1'b0;
            l2_hit_q <= 1'b0;
        end else begin
            valid_q  <= l2_grant_i.valid;
            ack_q    <= l2_grant_i.valid && (l2_grant_i.beat == '1); // Last beat
            l2_hit_q <= l2_grant_i.l2_hit;
        end
    end

    // Payload and invalidation fields pass straight through
    always_ff @(posedge clk_i) begin
        data_q      <= l2_grant_i.data;
        inv_valid_q <= l2_grant_i.inval;
        inv_paddr_q <= l2_grant_i.inval_addr;
    end

    assign ifill_resp_o.valid     = valid_q;
    assign ifill_resp_o.ack       = ack_q;
    assign ifill_resp_o.data      = data_q;
    assign ifill_resp_o.inv_valid = inv_valid_q;
    assign ifill_resp_o.inv_paddr = inv_paddr_q;

    assign l2_hit_evt_o = ack_q && l2_hit_q;  // Counted once per fill

    a_ack_needs_valid: assert property (
        @(posedge clk_i) disable iff (rst_i)
        ifill_resp_o.ack |-> ifill_resp_o.valid
    );

endmodule

/* pmu_event_counters.sv */
// ----------------------------------------------------------------------
// One wrapping counter per PMU event, read back by index
// iTLB stall bit of evt_i is ignored and formed here instead
// Counters count events, not cycles, except the iTLB stall event
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`include "tile_settings.svh"

module pmu_event_counters (
    input  logic               clk_i,
    input  logic               rst_i,
    input  tile_pkg::pmu_evt_t evt_i,
    input  logic               itlb_miss_i,
    input  logic               itlb_ready_i,
    input  tile_pkg::pmu_sel_t pmu_sel_i,
    output tile_pkg::pmu_cnt_t pmu_cnt_o
);

    tile_pkg::pmu_evt_t evt;
    tile_pkg::pmu_cnt_t cnt_q [`TILE_PMU_NEVT];
    logic               itlb_stall;

    // Miss held while the TLB cannot take a new lookup
    assign itlb_stall = itlb_miss_i && !itlb_ready_i;

    // ------------------------------------------------------------------
    // Event vector
    // ------------------------------------------------------------------
    always_comb begin
        evt                       = evt_i;
        evt[`TILE_EVT_ITLB_STALL] = itlb_stall;
    end

    // ------------------------------------------------------------------
    // Counter bank
    // ------------------------------------------------------------------
    for (genvar g = 0; g < `TILE_PMU_NEVT; g++) begin : gen_cnt
        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                cnt_q[g] <= '0;
            end else if (evt[g]) begin
                cnt_q[g] <= cnt_q[g] + 1'b1;  // Wraps at full scale
            end
        end
    end

    // Readout
    assign pmu_cnt_o = cnt_q[pmu_sel_i];

endmodule

/* tile_mem_glue.sv */
// ----------------------------------------------------------------------
// Tile memory glue top, walker bridge, fill port and PMU counters
// Data cache sees the walker on requester port 0 only
// No handshake beyond plain valid and ready levels
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`include "tile_settings.svh"

module tile_mem_glue (
    input  logic                    clk_i,
    input  logic                    rst_i,

    // Page table walker
    input  tile_pkg::ptw_dmem_req_t ptw_req_i,
    output logic                    ptw_ready_o,
    output tile_pkg::ptw_dmem_rsp_t ptw_rsp_o,

    // Data cache requester port 0
    output tile_pkg::dcache_req_t   dcache_req_o,
    input  logic                    dcache_ready_i,
    input  tile_pkg::dcache_rsp_t   dcache_rsp_i,

    // L2 network and instruction fill
    input  tile_pkg::l2_grant_t     l2_grant_i,
    output tile_pkg::ifill_resp_t   ifill_resp_o,

    // PMU
    input  logic                    itlb_miss_i,
    input  logic                    itlb_ready_i,
    input  tile_pkg::pmu_sel_t      pmu_sel_i,
    output tile_pkg::pmu_cnt_t      pmu_cnt_o
);

    logic [1:0]         ptw_evt;
    logic               l2_hit_evt;
    tile_pkg::pmu_evt_t pmu_evt;

    // ------------------------------------------------------------------
    // Walker to data cache
    // ------------------------------------------------------------------
    ptw_dmem_bridge ptw_dmem_bridge_i (
        .clk_i          ( clk_i          ),
        .rst_i          ( rst_i          ),
        .ptw_req_i      ( ptw_req_i      ),
        .ptw_ready_o    ( ptw_ready_o    ),
        .ptw_rsp_o      ( ptw_rsp_o      ),
        .dcache_req_o   ( dcache_req_o   ),
        .dcache_ready_i ( dcache_ready_i ),
        .dcache_rsp_i   ( dcache_rsp_i   ),
        .ptw_evt_o      ( ptw_evt        )
    );

    // ------------------------------------------------------------------
    // L2 grant to icache fill
    // ------------------------------------------------------------------
    icache_fill_port icache_fill_port_i (
        .clk_i        ( clk_i        ),
        .rst_i        ( rst_i        ),
        .l2_grant_i   ( l2_grant_i   ),
        .ifill_resp_o ( ifill_resp_o ),
        .l2_hit_evt_o ( l2_hit_evt   )
    );

    // Event vector
    assign pmu_evt[`TILE_EVT_L2_HIT]     = l2_hit_evt;
    assign pmu_evt[`TILE_EVT_ITLB_STALL] = 1'b0;        // Formed in the counters
    assign pmu_evt[`TILE_EVT_PTW_REQ]    = ptw_evt[0];
    assign pmu_evt[`TILE_EVT_PTW_AMO]    = ptw_evt[1];

    pmu_event_counters pmu_event_counters_i (
        .clk_i        ( clk_i        ),
        .rst_i        ( rst_i        ),
        .evt_i        ( pmu_evt      ),
        .itlb_miss_i  ( itlb_miss_i  ),
        .itlb_ready_i ( itlb_ready_i ),
        .pmu_sel_i    ( pmu_sel_i    ),
        .pmu_cnt_o    ( pmu_cnt_o    )
    );

endmodule

/* tb_tile_mem_glue.sv */
// ----------------------------------------------------------------------
// Testbench for the tile memory glue, all checks are assertions
// Behavioral data cache answers 1 to 4 cycles after acceptance
// One walker access in flight at a time, as the bridge requires
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`include "tile_settings.svh"

module tb_tile_mem_glue;

    localparam int n_items  = 48;                        // Walker accesses
    localparam int lane_bit = $clog2(`TILE_DATA_W/8);    // Just above the word offset
    localparam int limit    = 200 * (n_items + 2);       // Watchdog cycles

    logic                    clk = 1'b0;
    logic                    rst;
    tile_pkg::ptw_dmem_req_t ptw_req;
    logic                    ptw_ready;
    tile_pkg::ptw_dmem_rsp_t ptw_rsp;
    tile_pkg::dcache_req_t   dcache_req;
    logic                    dcache_ready;
    tile_pkg::dcache_rsp_t   dcache_rsp;
    tile_pkg::l2_grant_t     l2_grant;
    tile_pkg::ifill_resp_t   ifill_resp;
    logic                    itlb_miss;
    logic                    itlb_ready;
    tile_pkg::pmu_sel_t      pmu_sel;
    tile_pkg::pmu_cnt_t      pmu_cnt;

    integer                  seed = 32'hf592;
    logic                    bg_on = 1'b0;        // Random grants and iTLB activity
    logic                    outstanding = 1'b0;  // Walker access in flight
    tile_pkg::lane_idx_t     exp_lane = '0;       // Lane seen at acceptance
    tile_pkg::pmu_cnt_t      cnt_l2_hit = '0;
    tile_pkg::pmu_cnt_t      cnt_itlb = '0;
    tile_pkg::pmu_cnt_t      cnt_req = '0;
    tile_pkg::pmu_cnt_t      cnt_amo = '0;

    tile_mem_glue tile_mem_glue_i (
        .clk_i          ( clk          ),
        .rst_i          ( rst          ),
        .ptw_req_i      ( ptw_req      ),
        .ptw_ready_o    ( ptw_ready    ),
        .ptw_rsp_o      ( ptw_rsp      ),
        .dcache_req_o   ( dcache_req   ),
        .dcache_ready_i ( dcache_ready ),
        .dcache_rsp_i   ( dcache_rsp   ),
        .l2_grant_i     ( l2_grant     ),
        .ifill_resp_o   ( ifill_resp   ),
        .itlb_miss_i    ( itlb_miss    ),
        .itlb_ready_i   ( itlb_ready   ),
        .pmu_sel_i      ( pmu_sel      ),
        .pmu_cnt_o      ( pmu_cnt      )
    );

    always #5 clk = ~clk;

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    task automatic stop_on_failure(input string line);
        $display("%s", line);
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped after a failed check");
    endtask

    function automatic tile_pkg::data_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic tile_pkg::l2_line_t rand_line();
        tile_pkg::l2_line_t line;
        for (int i = 0; i < `TILE_L2_LINE_W / 32; i++) begin
            line[i*32 +: 32] = $random(seed);
        end
        return line;
    endfunction

    function automatic logic rand_ready();
        return ($random(seed) & 3) != 0;  // Low about a quarter of the time
    endfunction

    // Next falling edge, with fresh grant and iTLB inputs
    task automatic step();
        @(negedge clk);
        if (bg_on) begin
            itlb_miss           = 1'($random(seed));
            itlb_ready          = 1'($random(seed));
            l2_grant.valid      = 1'($random(seed));
            l2_grant.data       = rand_line();
            l2_grant.beat       = 2'($random(seed));
            l2_grant.inval      = 1'($random(seed));
            l2_grant.inval_addr = 12'($random(seed));
            l2_grant.l2_hit     = 1'($random(seed));
        end else begin
            itlb_miss  = 1'b0;
            itlb_ready = 1'b1;
            l2_grant   = '0;
        end
    endtask

    // Fresh walker request, held until the bridge takes it
    task automatic present_request();
        logic amo;
        amo           = 1'($random(seed));
        ptw_req.valid = 1'b1;
        ptw_req.cmd   = amo ? `TILE_PTW_CMD_AMO_OR : 5'($random(seed));
        if (!amo && ptw_req.cmd == `TILE_PTW_CMD_AMO_OR) begin
            ptw_req.cmd = '0;
        end
        ptw_req.size  = 3'd3;
        ptw_req.addr  = tile_pkg::addr_t'(rand_word());
        ptw_req.data  = rand_word();
    endtask

    // One walker access served by the data-cache model
    task automatic walker_access();
        int unsigned delay;
        step();
        if (!ptw_req.valid) begin
            present_request();
        end
        dcache_ready  = rand_ready();
        forever begin                               // Held until the bridge takes it
            @(posedge clk);
            if (ptw_ready) break;
            step();
            dcache_ready = rand_ready();
        end
        exp_lane    = ptw_req.addr[lane_bit];
        outstanding = 1'b1;
        cnt_req++;
        if (ptw_req.cmd == `TILE_PTW_CMD_AMO_OR) begin
            cnt_amo++;
        end
        delay = 1 + ($random(seed) & 3);
        step();
        // Walker inputs change while the access is in flight
        ptw_req.valid = 1'b0;
        ptw_req.addr  = tile_pkg::addr_t'(rand_word());
        ptw_req.cmd   = 5'($random(seed));
        ptw_req.data  = rand_word();
        dcache_ready  = rand_ready();
        repeat (delay - 1) begin
            step();
            dcache_ready = rand_ready();
            if (!ptw_req.valid) begin
                present_request();                  // Next request waits behind this one
            end
        end
        dcache_rsp.valid = 1'b1;
        dcache_rsp.rdata = {rand_word(), rand_word()};
        @(posedge clk);
        outstanding = 1'b0;
        step();
        dcache_rsp.valid = 1'b0;
        dcache_ready     = 1'b0;                    // Pending request goes to the next access
    endtask

    task automatic check_counters();
        tile_pkg::pmu_cnt_t want [`TILE_PMU_NEVT];
        want[`TILE_EVT_L2_HIT]     = cnt_l2_hit;
        want[`TILE_EVT_ITLB_STALL] = cnt_itlb;
        want[`TILE_EVT_PTW_REQ]    = cnt_req;
        want[`TILE_EVT_PTW_AMO]    = cnt_amo;
        for (int i = 0; i < `TILE_PMU_NEVT; i++) begin
            step();
            pmu_sel = tile_pkg::pmu_sel_t'(i);
            @(posedge clk);
            assert (pmu_cnt == want[i]) else stop_on_failure($sformatf(
                "Error at %0t ns: counter %0d reads %0d, expected %0d",
                $time, i, pmu_cnt, want[i]));
        end
    endtask

    // Reference event counts
    always @(posedge clk) begin
        if (!rst) begin
            if (l2_grant.valid && l2_grant.beat == 2'd3 && l2_grant.l2_hit) begin
                cnt_l2_hit++;
            end
            if (itlb_miss && !itlb_ready) begin
                cnt_itlb++;
            end
        end
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    a_req_valid: assert property (@(posedge clk) disable iff (rst)
        dcache_req.valid == (ptw_req.valid && !outstanding))
        else stop_on_failure($sformatf("Error at %0t ns: wrong request valid", $time));

    a_ready_level: assert property (@(posedge clk) disable iff (rst)
        !outstanding |-> ptw_ready == dcache_ready)
        else stop_on_failure($sformatf("Error at %0t ns: ready ignores cache", $time));

    a_busy_quiet: assert property (@(posedge clk) disable iff (rst)
        outstanding |-> !ptw_ready && !dcache_req.valid)
        else stop_on_failure($sformatf("Error at %0t ns: request while busy", $time));

    a_req_fields: assert property (@(posedge clk) disable iff (rst)
        dcache_req.valid |-> {dcache_req.addr_tag, dcache_req.addr_offset} == ptw_req.addr
            && dcache_req.size == ptw_req.size && dcache_req.need_rsp
            && dcache_req.phys_indexed
            && dcache_req.wdata[ptw_req.addr[lane_bit]] == ptw_req.data
            && dcache_req.wdata[~ptw_req.addr[lane_bit]] == '0)
        else stop_on_failure($sformatf("Error at %0t ns: bad address or data", $time));

    a_load_op: assert property (@(posedge clk) disable iff (rst)
        (dcache_req.valid && ptw_req.cmd != `TILE_PTW_CMD_AMO_OR)
            |-> dcache_req.op == tile_pkg::DMEM_OP_LOAD && dcache_req.be == '0)
        else stop_on_failure($sformatf("Error at %0t ns: bad load request", $time));

    a_amo_op: assert property (@(posedge clk) disable iff (rst)
        (dcache_req.valid && ptw_req.cmd == `TILE_PTW_CMD_AMO_OR)
            |-> dcache_req.op == tile_pkg::DMEM_OP_AMO_OR
            && dcache_req.be[ptw_req.addr[lane_bit]] == 8'hff
            && dcache_req.be[~ptw_req.addr[lane_bit]] == 8'h00)
        else stop_on_failure($sformatf("Error at %0t ns: bad AMO-OR request", $time));

    a_rsp_word: assert property (@(posedge clk) disable iff (rst)
        ptw_rsp.valid == dcache_rsp.valid
            && (dcache_rsp.valid -> ptw_rsp.data == dcache_rsp.rdata[exp_lane]))
        else stop_on_failure($sformatf("Error at %0t ns: wrong walker response", $time));

    a_fill_resp: assert property (@(posedge clk) disable iff (rst)
        l2_grant.valid |=> ifill_resp.valid
            && ifill_resp.data == $past(l2_grant.data)
            && ifill_resp.inv_valid == $past(l2_grant.inval)
            && ifill_resp.inv_paddr == $past(l2_grant.inval_addr)
            && ifill_resp.ack == ($past(l2_grant.beat) == 2'd3))
        else stop_on_failure($sformatf("Error at %0t ns: wrong fill response", $time));

    a_fill_idle: assert property (@(posedge clk) disable iff (rst)
        !l2_grant.valid |=> !ifill_resp.valid && !ifill_resp.ack)
        else stop_on_failure($sformatf("Error at %0t ns: fill without grant", $time));

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial begin : watchdog
        repeat (limit) @(posedge clk);
        stop_on_failure($sformatf("Timeout: the run did not end within %0d cycles", limit));
    end

    initial begin : stimulus
        rst          = 1'b1;
        ptw_req      = '0;
        dcache_ready = 1'b0;
        dcache_rsp   = '0;
        l2_grant     = '0;
        itlb_miss    = 1'b0;
        itlb_ready   = 1'b1;
        pmu_sel      = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        assert (!ifill_resp.valid && !ifill_resp.ack && !ptw_rsp.valid)
            else stop_on_failure($sformatf("Error at %0t ns: outputs not idle after reset",
                                           $time));
        check_counters();                   // All zero after reset
        bg_on = 1'b1;
        for (int i = 0; i < n_items; i++) begin
            walker_access();
        end
        bg_on = 1'b0;
        repeat (3) begin
            step();                         // Drain the fill register
        end
        check_counters();
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* all.f */
+incdir+.
tile_pkg.sv
ptw_dmem_bridge.sv
icache_fill_port.sv
pmu_event_counters.sv
tile_mem_glue.sv
tb_tile_mem_glue.sv

/* Bender.yml */
package:
  name: tile_mem_glue

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - tile_pkg.sv
      - ptw_dmem_bridge.sv
      - icache_fill_port.sv
      - pmu_event_counters.sv
      - tile_mem_glue.sv
      - target: test
        files:
          - tb_tile_mem_glue.sv
